/* alu_pipeline.sv */
// --------------------------------------------------------------------
// Three-stage arithmetic pipeline that accepts one request per cycle
// and never stalls. Results leave exactly three cycles after issue.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module alu_pipeline (
    input  logic                     aclk,
    input  logic                     resetn,
    input  logic                     issue_valid,
    input  stream_alu_pkg::alu_req_t issue_req,
    output logic                     done_valid,
    output stream_alu_pkg::alu_rsp_t done_rsp
);

    // One-hot operation select, bit order add, sub, mul, xor
    logic [3:0]                          op_sel;

    // Stage one holds the operands and the decoded select
    logic                                s1_valid;
    logic [3:0]                          s1_sel;
    logic [stream_alu_pkg::data_w-1:0]   s1_a;
    logic [stream_alu_pkg::data_w-1:0]   s1_b;
    logic                                s1_last;

    // Combinational results computed from stage one
    logic [stream_alu_pkg::data_w-1:0]   sum;
    logic [stream_alu_pkg::data_w-1:0]   diff;
    logic [stream_alu_pkg::data_w-1:0]   prod;
    logic [stream_alu_pkg::data_w-1:0]   bits;
    logic [stream_alu_pkg::data_w-1:0]   result;

    // Stage two holds the selected result
    logic                                s2_valid;
    logic [stream_alu_pkg::data_w-1:0]   s2_result;
    logic                                s2_last;

    // Stage three is the response register
    logic                                s3_valid;
    stream_alu_pkg::alu_rsp_t            s3_rsp;

    always_comb
    begin
        op_sel = 4'b0000;
        case (issue_req.op)
            stream_alu_pkg::op_add: op_sel = 4'b0001;
            stream_alu_pkg::op_sub: op_sel = 4'b0010;
            stream_alu_pkg::op_mul: op_sel = 4'b0100;
            stream_alu_pkg::op_xor: op_sel = 4'b1000;
            default:                op_sel = 4'b0000;
        endcase
    end

    // All four results wrap modulo 2 to the data width
    assign sum  = s1_a + s1_b;
    assign diff = s1_a - s1_b;
    // Only the low half of the product is kept
    assign prod = s1_a * s1_b;
    assign bits = s1_a ^ s1_b;

    // AND-OR mux driven by the one-hot select
    assign result = ({stream_alu_pkg::data_w{s1_sel[0]}} & sum)
                  | ({stream_alu_pkg::data_w{s1_sel[1]}} & diff)
                  | ({stream_alu_pkg::data_w{s1_sel[2]}} & prod)
                  | ({stream_alu_pkg::data_w{s1_sel[3]}} & bits);

    // Valid bits shift along with the data, one per stage
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // Payload moves every cycle; stale words are masked by the valid bits
    always_ff @(posedge aclk)
    begin
        s1_sel           <= op_sel;
        s1_a             <= issue_req.a;
        s1_b             <= issue_req.b;
        s1_last          <= issue_req.last;
        s2_result        <= result;
        s2_last          <= s1_last;
        s3_rsp.result    <= s2_result;
        s3_rsp.last      <= s2_last;
    end

    assign done_valid = s3_valid;
    assign done_rsp   = s3_rsp;

endmodule

/* project.f */
stream_alu_pkg.sv
skid_buffer.sv
stream_semaphore.sv
alu_pipeline.sv
result_fifo.sv
stream_alu.sv
stream_alu_chk.sv
tb_stream_alu.sv

/* result_fifo.sv */
// --------------------------------------------------------------------
// Synchronous first-word-fall-through FIFO for pipeline responses.
// Pushes are never refused, the upstream semaphore reserves space.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module result_fifo #(
    parameter int depth = 8
) (
    input  logic                     aclk,
    input  logic                     resetn,
    input  logic                     push,
    input  stream_alu_pkg::alu_rsp_t push_rsp,
    output logic                     pop_valid,
    input  logic                     pop_ready,
    output stream_alu_pkg::alu_rsp_t pop_rsp
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);
    // Highest slot index, pointers wrap here so depth need not be a power of two
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(depth - 1);

    stream_alu_pkg::alu_rsp_t mem [depth];
    logic [ptr_w-1:0]         wr_ptr;
    logic [ptr_w-1:0]         rd_ptr;
    logic [cnt_w-1:0]         count;
    // Downstream takes the head word this cycle
    logic                     pop;

    // Head word is read straight from storage
    assign pop_valid = (count != '0);
    assign pop_rsp   = mem[rd_ptr];
    assign pop       = pop_valid && pop_ready;

    always_ff @(posedge aclk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_rsp;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy only moves when exactly one side is active
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (!push && pop)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Builds the stream_alu testbench with Verilator, runs it and looks for
# the pass message in its output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_stream_alu -o sim_stream_alu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_stream_alu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* skid_buffer.sv */
// --------------------------------------------------------------------
// Two-entry skid buffer with a registered output word and registered
// input ready, so no combinational path runs from out_ready to in_ready.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module skid_buffer #(
    parameter int width = 8
) (
    input  logic             aclk,
    input  logic             resetn,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_data
);

    // Side word catches one item that arrives while the output is stuck
    logic             side_valid;
    logic [width-1:0] side_data;
    // Input handshake completes this cycle
    logic             in_take;
    // Output register is empty or is being drained this cycle
    logic             out_free;
    // Occupancy of the side word after this cycle's edge
    logic             side_next;

    assign in_take  = in_valid && in_ready;
    assign out_free = !out_valid || out_ready;

    always_comb
    begin
        side_next = side_valid;
        // A free output always drains the side word first
        if (side_valid && out_free)
        begin
            side_next = 1'b0;
        end
        // New item with a blocked output has to park in the side word
        else if (in_take && !out_free)
        begin
            side_next = 1'b1;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            out_valid  <= 1'b0;
            side_valid <= 1'b0;
            // Input stays closed until the first cycle after reset
            in_ready   <= 1'b0;
        end
        else
        begin
            side_valid <= side_next;
            // Ready only while the side word can still take an item
            in_ready   <= !side_next;
            if (out_free)
            begin
                out_valid <= side_valid || in_take;
            end
        end
    end

    // Payload registers carry no reset, the valid flags qualify them
    always_ff @(posedge aclk)
    begin
        if (out_free)
        begin
            // Older side item goes out ahead of anything on the input
            out_data <= side_valid ? side_data : in_data;
        end
        if (in_take && !out_free)
        begin
            side_data <= in_data;
        end
    end

endmodule

/* stream_alu.sv */
// --------------------------------------------------------------------
// Top level of the streaming ALU. Requests enter on the s port and
// responses leave in order on the m port, both valid/ready.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module stream_alu #(
    parameter int max_in_flight = 8
) (
    input  logic                     aclk,
    input  logic                     resetn,
    input  logic                     s_valid,
    output logic                     s_ready,
    input  stream_alu_pkg::alu_req_t s_req,
    output logic                     m_valid,
    input  logic                     m_ready,
    output stream_alu_pkg::alu_rsp_t m_rsp,
    output logic                     idle
);

    // Semaphore to pipeline, no ready on this path
    logic                     issue_valid;
    stream_alu_pkg::alu_req_t issue_req;
    // Pipeline to FIFO push side
    logic                     done_valid;
    stream_alu_pkg::alu_rsp_t done_rsp;
    // A response leaves the design this cycle
    logic                     pop;

    assign pop = m_valid && m_ready;

    // Gates entry so the FIFO below can never overflow
    stream_semaphore #(
        .max_in_flight(max_in_flight)
    ) semaphore_inst (
        .aclk        (aclk),
        .resetn      (resetn),
        .s_valid     (s_valid),
        .s_ready     (s_ready),
        .s_req       (s_req),
        .release_item(pop),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .idle        (idle)
    );

    alu_pipeline pipeline_inst (
        .aclk       (aclk),
        .resetn     (resetn),
        .issue_valid(issue_valid),
        .issue_req  (issue_req),
        .done_valid (done_valid),
        .done_rsp   (done_rsp)
    );

    // Depth equals the in-flight limit so every issued item has a slot
    result_fifo #(
        .depth(max_in_flight)
    ) fifo_inst (
        .aclk     (aclk),
        .resetn   (resetn),
        .push     (done_valid),
        .push_rsp (done_rsp),
        .pop_valid(m_valid),
        .pop_ready(m_ready),
        .pop_rsp  (m_rsp)
    );

endmodule

/* stream_alu_chk.sv */
// --------------------------------------------------------------------
// Concurrent assertions on the stream_alu ports, bound to every
// stream_alu instance so the testbench needs no extra wiring.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module stream_alu_chk (
    input logic                     aclk,
    input logic                     resetn,
    input logic                     s_valid,
    input logic                     s_ready,
    input stream_alu_pkg::alu_req_t s_req,
    input logic                     m_valid,
    input logic                     m_ready,
    input stream_alu_pkg::alu_rsp_t m_rsp,
    input logic                     idle
);

    // With nothing counted in flight the FIFO has to be empty
    idle_blocks_output: assert property (@(posedge aclk) disable iff (!resetn)
        idle |-> !m_valid) else $error("m_valid high while idle");

    // A stalled request keeps its valid and payload
    s_hold: assert property (@(posedge aclk) disable iff (!resetn)
        s_valid && !s_ready |=> s_valid && $stable(s_req)) else $error("s port dropped");

    // Same rule on the response side, driven by the DUT
    m_hold: assert property (@(posedge aclk) disable iff (!resetn)
        m_valid && !m_ready |=> m_valid && $stable(m_rsp)) else $error("m port dropped");

    // Reset closes the input on the following cycle
    reset_closes_input: assert property (@(posedge aclk)
        !resetn |=> !s_ready) else $error("s_ready high after reset");

endmodule

bind stream_alu stream_alu_chk chk_inst (
    .aclk   (aclk),
    .resetn (resetn),
    .s_valid(s_valid),
    .s_ready(s_ready),
    .s_req  (s_req),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_rsp  (m_rsp),
    .idle   (idle)
);

/* stream_alu_pkg.sv */
// --------------------------------------------------------------------
// Shared types and constants for the streaming integer ALU.
// Modules refer to these through scoped names on the package.
// --------------------------------------------------------------------
package stream_alu_pkg;

    // Width of each operand and of the result word
    localparam int data_w = 16;

    // Number of register stages in the arithmetic pipeline
    localparam int pipe_depth = 3;

    // Operation selector carried with each request
    typedef enum logic [1:0] {
        // Sum of a and b
        op_add = 2'd0,
        // Difference a minus b
        op_sub = 2'd1,
        // Low half of the full product
        op_mul = 2'd2,
        // Bitwise exclusive or
        op_xor = 2'd3
    } alu_op_t;

    // One request word as it travels from the input port to the pipeline
    // Layout from the top bit down is op, a, b, last (35 bits)
    typedef struct packed {
        alu_op_t              op;
        logic [data_w-1:0]    a;
        logic [data_w-1:0]    b;
        // Marks the final word of a packet, passed through untouched
        logic                 last;
    } alu_req_t;

    // One response word as it leaves the pipeline and the FIFO
    // Layout from the top bit down is result, last (17 bits)
    typedef struct packed {
        logic [data_w-1:0]    result;
        // Copied from the matching request
        logic                 last;
    } alu_rsp_t;

endpackage

/* stream_semaphore.sv */
// --------------------------------------------------------------------
// Flow control in front of the non-stalling pipeline. Counts items in
// flight up to the FIFO output and only issues while there is room.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module stream_semaphore #(
    parameter int max_in_flight = 8
) (
    input  logic                     aclk,
    input  logic                     resetn,
    input  logic                     s_valid,
    output logic                     s_ready,
    input  stream_alu_pkg::alu_req_t s_req,
    input  logic                     release_item,
    output logic                     issue_valid,
    output stream_alu_pkg::alu_req_t issue_req,
    output logic                     idle
);

    // Counter must hold every value from zero up to the limit itself
    localparam int cnt_w = $clog2(max_in_flight + 1);
    localparam logic [cnt_w-1:0] limit = cnt_w'(max_in_flight);

    logic [cnt_w-1:0] count;
    // Skid buffer holds a request ready to go
    logic             buffered_valid;
    // Room remains downstream for one more item
    logic             free;

    assign free = (count < limit);

    // Input side of the semaphore is decoupled by a skid buffer
    skid_buffer #(
        .width($bits(stream_alu_pkg::alu_req_t))
    ) skid_inst (
        .aclk     (aclk),
        .resetn   (resetn),
        .in_valid (s_valid),
        .in_ready (s_ready),
        .in_data  (s_req),
        .out_valid(buffered_valid),
        .out_ready(free),
        .out_data (issue_req)
    );

    // The pipeline has no ready, so an offered item is taken at once
    assign issue_valid = buffered_valid && free;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            count <= '0;
            idle  <= 1'b1;
        end
        else
        begin
            // Issue and release in the same cycle cancel out
            if (issue_valid && !release_item)
            begin
                count <= count + 1'b1;
            end
            else if (!issue_valid && release_item)
            begin
                count <= count - 1'b1;
            end
            // Idle lags the count by one cycle
            idle <= (count == '0);
        end
    end

endmodule

/* tb_stream_alu.sv */
// --------------------------------------------------------------------
// Testbench for stream_alu. Drives seeded random requests, stalls the
// output side at random and checks each response against a queue model.
// --------------------------------------------------------------------
`timescale 1ns/1ps

module tb_stream_alu;

    localparam int clk_period     = 20;
    localparam int reset_cycles   = 8;
    localparam int max_in_flight  = 8;
    localparam int n_random       = 300;
    // Skid register, pipeline stages and FIFO register
    localparam int min_latency    = stream_alu_pkg::pipe_depth + 2;
    localparam int timeout_cycles = n_random * 16 + reset_cycles + 8 * min_latency;

    logic                     aclk;
    logic                     resetn;
    logic                     s_valid;
    logic                     s_ready;
    stream_alu_pkg::alu_req_t s_req;
    logic                     m_valid;
    logic                     m_ready;
    stream_alu_pkg::alu_rsp_t m_rsp;
    logic                     idle;

    // Expected responses, oldest at the front
    stream_alu_pkg::alu_rsp_t exp_q[$];
    logic [31:0]              rng_state;
    logic [31:0]              r;
    logic                     s_took;
    // Request being offered, held until the DUT takes it
    logic                     pend_valid;
    stream_alu_pkg::alu_req_t pend_req;
    logic                     low_mode;
    logic                     ready_pick;
    int                       stretch;
    // Cycles since the last transfer on either port
    int                       quiet;
    int                       issued;
    int                       accepted;
    int                       latency;
    int                       cycle_count;
    int                       value_errors;
    int                       other_errors;

    stream_alu #(
        .max_in_flight(max_in_flight)
    ) stream_alu_inst (
        .aclk   (aclk),
        .resetn (resetn),
        .s_valid(s_valid),
        .s_ready(s_ready),
        .s_req  (s_req),
        .m_valid(m_valid),
        .m_ready(m_ready),
        .m_rsp  (m_rsp),
        .idle   (idle)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    // Run limit covers the random traffic, reset and the directed phases
    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge aclk);
            cycle_count++;
        end
        $display("Error: run timed out after %0d cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic stream_alu_pkg::alu_req_t random_req();
        stream_alu_pkg::alu_req_t req;
        logic [31:0]              r1;
        logic [31:0]              r2;
        r1 = next_rand();
        r2 = next_rand();
        req.op   = stream_alu_pkg::alu_op_t'(r1[1:0]);
        req.a    = r1[31:16];
        req.b    = r2[31:16];
        req.last = r2[0];
        return req;
    endfunction

    // Reference result, computed wide and cut to the data width
    function automatic stream_alu_pkg::alu_rsp_t expected_rsp(
        input stream_alu_pkg::alu_req_t req
    );
        stream_alu_pkg::alu_rsp_t rsp;
        logic [31:0]              full;
        case (req.op)
            stream_alu_pkg::op_add: full = 32'(req.a) + 32'(req.b);
            stream_alu_pkg::op_sub: full = 32'(req.a) - 32'(req.b);
            stream_alu_pkg::op_mul: full = 32'(req.a) * 32'(req.b);
            default:                full = 32'(req.a ^ req.b);
        endcase
        rsp.result = full[stream_alu_pkg::data_w-1:0];
        rsp.last   = req.last;
        return rsp;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("Fail %s got %h expected %h", name, got, expected);
            value_errors++;
        end
    endtask

    task automatic check_response();
        stream_alu_pkg::alu_rsp_t expected;
        if (exp_q.size() == 0)
        begin
            $display("Error: response arrived with no request outstanding");
            other_errors++;
        end
        else
        begin
            expected = exp_q.pop_front();
            if (m_rsp.result !== expected.result)
            begin
                $display("Fail m_rsp.result got %h expected %h", m_rsp.result, expected.result);
                value_errors++;
            end
            if (m_rsp.last !== expected.last)
            begin
                $display("Fail m_rsp.last got %h expected %h", m_rsp.last, expected.last);
                value_errors++;
            end
        end
    endtask

    // Drive one cycle on the falling edge and record the transfers that the
    // next rising edge will make, since outputs only move on that edge
    task automatic cycle_step(input logic valid_in, input stream_alu_pkg::alu_req_t req_in,
                              input logic ready_in);
        logic popped;
        @(negedge aclk);
        s_valid = valid_in;
        s_req   = req_in;
        m_ready = ready_in;
        s_took  = s_valid && s_ready;
        popped  = m_valid && m_ready;
        if (popped)
        begin
            check_response();
        end
        if (s_took)
        begin
            exp_q.push_back(expected_rsp(s_req));
        end
        if (s_took || popped)
        begin
            quiet = 0;
        end
        else
        begin
            quiet++;
        end
        // Idle trails each transfer by up to three cycles
        if (quiet >= 3)
        begin
            check_bit("idle", idle, exp_q.size() == 0);
        end
    endtask

    task automatic drain_responses();
        while (exp_q.size() != 0)
        begin
            cycle_step(1'b0, pend_req, 1'b1);
        end
    endtask

    initial
    begin
        rng_state    = 32'h181ec306;
        resetn       = 1'b0;
        s_valid      = 1'b0;
        s_req        = '0;
        m_ready      = 1'b0;
        pend_valid   = 1'b0;
        pend_req     = '0;
        low_mode     = 1'b0;
        stretch      = 0;
        quiet        = 0;
        value_errors = 0;
        other_errors = 0;
        repeat (reset_cycles) @(posedge aclk);
        @(negedge aclk);
        check_bit("s_ready", s_ready, 1'b0);
        check_bit("m_valid", m_valid, 1'b0);
        check_bit("idle", idle, 1'b1);
        resetn = 1'b1;
        // First cycle out of reset opens the input
        @(negedge aclk);
        check_bit("s_ready", s_ready, 1'b1);
        check_bit("m_valid", m_valid, 1'b0);
        check_bit("idle", idle, 1'b1);

        // Single request through the empty design with the output open
        cycle_step(1'b1, random_req(), 1'b1);
        if (!s_took)
        begin
            $display("Error: first request after reset was not accepted");
            other_errors++;
        end
        latency = 0;
        while (exp_q.size() != 0)
        begin
            cycle_step(1'b0, s_req, 1'b1);
            latency++;
        end
        if (latency != min_latency)
        begin
            $display("Fail latency got %h expected %h", latency, min_latency);
            value_errors++;
        end

        // Output blocked, so the FIFO and both skid entries fill up
        accepted = 0;
        repeat (30)
        begin
            if (!pend_valid)
            begin
                pend_valid = 1'b1;
                pend_req   = random_req();
            end
            cycle_step(pend_valid, pend_req, 1'b0);
            if (s_took)
            begin
                pend_valid = 1'b0;
                accepted++;
            end
        end
        if (accepted != max_in_flight + 2)
        begin
            $display("Fail accepted count got %h expected %h", accepted, max_in_flight + 2);
            value_errors++;
        end
        check_bit("s_ready", s_ready, 1'b0);
        // The held request still goes in once the output opens
        while (pend_valid)
        begin
            cycle_step(1'b1, pend_req, 1'b1);
            if (s_took)
            begin
                pend_valid = 1'b0;
            end
        end
        drain_responses();

        // Random traffic with gaps on the input and stalls on the output
        issued = 0;
        while (issued < n_random)
        begin
            r = next_rand();
            if (!pend_valid && r[1:0] != 2'b00)
            begin
                pend_valid = 1'b1;
                pend_req   = random_req();
            end
            if (stretch == 0)
            begin
                // Now and then a long stall, otherwise a short busy stretch
                low_mode = (r[7:4] == 4'h0);
                stretch  = low_mode ? 12 + int'(r[12:8]) : 4 + int'(r[10:8]);
            end
            stretch--;
            ready_pick = !low_mode && (r[15:14] != 2'b00);
            cycle_step(pend_valid, pend_req, ready_pick);
            if (s_took)
            begin
                pend_valid = 1'b0;
                issued++;
            end
        end
        drain_responses();
        repeat (4) cycle_step(1'b0, pend_req, 1'b1);
        check_bit("idle", idle, 1'b1);
        check_bit("m_valid", m_valid, 1'b0);

        $display("Errors: value mismatches %0d, other failures %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
